/* compile.f */
core_pkg.sv
exec_result_if.sv
regfile.sv
exec_unit.sv
core_ctrl_fsm.sv
retire_counter.sv
cpu.sv
tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim | tee sim.log
if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* tb_cpu.sv */
// directed testbench with bus memory model, LFSR, reference model and compare tasks
`timescale 1ns/1ps

module tb_cpu
  import core_pkg::*;
();

  // about 60 instructions at up to 12 cycles each plus reset and halt checks per run
  localparam int MAX_CYCLES = 4000;

  logic       clock = 1'b0;
  logic       reset;
  logic       if_rw_valid;
  logic       if_rw_ready;
  word_t      if_rw_addr;
  word_t      if_r_data;
  logic [1:0] if_rw_resp;
  logic       mem_rw_valid;
  logic       mem_rw_ready;
  logic       mem_rw_req;
  word_t      mem_rw_addr;
  word_t      mem_w_data;
  word_t      mem_r_data;
  logic [1:0] mem_rw_resp;
  logic       commit_valid;
  word_t      commit_pc;
  word_t      commit_inst;
  logic       commit_wen;
  reg_addr_t  commit_rd;
  word_t      commit_data;
  logic       halted;
  logic       fault;
  word_t      cycle_count;
  word_t      instr_count;

  word_t mem [0:255];
  word_t prog [$];
  word_t lfsr_state = 32'h489b_257b;
  int    if_wait;
  int    mem_wait;
  bit    if_pending;
  bit    mem_pending;
  word_t fetch_err_addr = 32'hffff_ffff;
  bit    load_err = 1'b0;
  int    cycles = 0;
  int    checks = 0;
  int    errors = 0;
  int    tests_run = 0;
  int    errors_at_start;
  string test_name;

  // reference model state
  word_t m_mem [0:255];
  word_t m_regs [0:31];
  word_t m_pc;
  bit    m_halted;

  cpu #(.RESET_PC(32'h0000_0000)) DUT (.*);

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: simulation did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic int draw_bits(input int n);
    int   value;
    logic fb;
    value = 0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = (value << 1) | int'(fb);
    end
    return value;
  endfunction

  // memory model raises ready after 0 to 3 random wait cycles per request
  always @(posedge clock) begin
    if (reset) begin
      if_rw_ready  <= 1'b0;
      mem_rw_ready <= 1'b0;
      if_pending   = 1'b0;
      mem_pending  = 1'b0;
    end else begin
      if (if_rw_ready) begin
        if_rw_ready <= 1'b0;
        if_pending  = 1'b0;
      end else if (if_rw_valid) begin
        if (!if_pending) begin
          if_wait    = draw_bits(2);
          if_pending = 1'b1;
        end
        if (if_wait == 0) begin
          if_rw_ready <= 1'b1;
          if_r_data   <= mem[if_rw_addr[9:2]];
          if_rw_resp  <= (if_rw_addr == fetch_err_addr) ? 2'b10 : RESP_OKAY;
        end else begin
          if_wait = if_wait - 1;
        end
      end
      if (mem_rw_ready) begin
        // valid is still held on the transfer edge
        if (mem_rw_req) mem[mem_rw_addr[9:2]] = mem_w_data;
        mem_rw_ready <= 1'b0;
        mem_pending  = 1'b0;
      end else if (mem_rw_valid) begin
        if (!mem_pending) begin
          mem_wait    = draw_bits(2);
          mem_pending = 1'b1;
        end
        if (mem_wait == 0) begin
          mem_rw_ready <= 1'b1;
          mem_r_data   <= mem[mem_rw_addr[9:2]];
          mem_rw_resp  <= (load_err && !mem_rw_req) ? 2'b10 : RESP_OKAY;
        end else begin
          mem_wait = mem_wait - 1;
        end
      end
    end
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_reg_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // instruction encoders for the RV32I formats
  function automatic word_t rtype(input int f7, input int f3, input int rd, input int rs1,
                                  input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic word_t addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM};
  endfunction

  function automatic word_t lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
  endfunction

  function automatic word_t sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t branch(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t lui(input int rd, input logic [19:0] imm);
    return {imm, rd[4:0], OPC_LUI};
  endfunction

  // next commit as the ISA defines it with ok low if nothing should retire
  task automatic model_step(output word_t e_pc, output word_t e_inst, output logic e_wen,
                            output reg_addr_t e_rd, output word_t e_data, output logic ok);
    word_t inst;
    word_t a;
    word_t b;
    word_t imm_i;
    word_t addr;
    word_t next_pc;
    logic  writes;
    inst    = m_mem[m_pc[9:2]];
    a       = m_regs[inst[19:15]];
    b       = m_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    next_pc = m_pc + 32'd4;
    writes  = 1'b0;
    e_data  = '0;
    ok      = !m_halted;
    case (inst[6:0])
      OPC_LUI: begin
        writes = 1'b1;
        e_data = {inst[31:12], 12'h000};
      end
      OPC_OP_IMM: begin
        writes = 1'b1;
        e_data = a + imm_i;
        ok     = ok && (inst[14:12] == 3'b000);
      end
      OPC_OP: begin
        writes = 1'b1;
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: e_data = a + b;
          10'b0100000_000: e_data = a - b;
          10'b0000000_100: e_data = a ^ b;
          10'b0000000_110: e_data = a | b;
          10'b0000000_111: e_data = a & b;
          default: ok = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        writes = 1'b1;
        addr   = a + imm_i;
        e_data = m_mem[addr[9:2]];
      end
      OPC_STORE: begin
        addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        m_mem[addr[9:2]] = b;
      end
      OPC_BRANCH: begin
        ok = ok && (inst[14:13] == 2'b00);
        if ((inst[12] == 1'b0) ? (a == b) : (a != b)) begin
          next_pc = m_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      OPC_TRAP: m_halted = 1'b1;
      default: ok = 1'b0;
    endcase
    e_pc   = m_pc;
    e_inst = inst;
    e_rd   = inst[11:7];
    e_wen  = writes && (e_rd != '0);
    if (e_wen) m_regs[e_rd] = e_data;
    m_pc = next_pc;
  endtask

  task automatic check_commit();
    word_t     e_pc;
    word_t     e_inst;
    word_t     e_data;
    logic      e_wen;
    logic      ok;
    reg_addr_t e_rd;
    model_step(e_pc, e_inst, e_wen, e_rd, e_data, ok);
    if (!ok) begin
      errors++;
      $display("[ERROR] %t: commit at pc %h where none should retire", $time, commit_pc);
    end
    check_word("commit_pc", commit_pc, e_pc);
    check_word("commit_inst", commit_inst, e_inst);
    check_flag("commit_wen", commit_wen, e_wen);
    check_reg_addr("commit_rd", commit_rd, e_rd);
    if (e_wen) check_word("commit_data", commit_data, e_data);
  endtask

  // load program, reset, check every commit, then check the halted core
  task automatic run_program(input int exp_commits, input logic exp_fault);
    int commits;
    int cycles_run;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {24'hc0ffee, i[7:0]};
    end
    foreach (prog[i]) mem[i] = prog[i];
    m_mem    = mem;
    m_pc     = '0;
    m_halted = 1'b0;
    foreach (m_regs[i]) m_regs[i] = '0;
    @(posedge clock);
    reset <= 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_flag("fetch request after reset", if_rw_valid, 1'b1);
    check_flag("data request after reset", mem_rw_valid, 1'b0);
    check_flag("halted after reset", halted, 1'b0);
    check_flag("fault after reset", fault, 1'b0);
    commits    = 0;
    cycles_run = 0;
    do begin
      @(negedge clock);
      // each edge up to and including the halting one is counted
      cycles_run++;
      if (commit_valid) begin
        commits++;
        check_commit();
      end
    end while (!halted);
    repeat (6) begin
      @(negedge clock);
      check_flag("fetch request after halt", if_rw_valid, 1'b0);
      check_flag("data request after halt", mem_rw_valid, 1'b0);
      check_flag("commit after halt", commit_valid, 1'b0);
      check_word("cycle_count after halt", cycle_count, word_t'(cycles_run));
    end
    check_word("instr_count", instr_count, word_t'(commits));
    check_word("number of commits", word_t'(commits), word_t'(exp_commits));
    check_flag("fault", fault, exp_fault);
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    tests_run++;
    prog.delete();
  endtask

  task automatic end_test();
    if (errors == errors_at_start) $display("test %s: ok", test_name);
    else $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
  endtask

  task automatic test_arithmetic();
    begin_test("arithmetic");
    prog.push_back(lui(1, 20'h12345));
    prog.push_back(addi(2, 0, 'h678));
    prog.push_back(rtype('h00, 0, 3, 1, 2));
    prog.push_back(rtype('h20, 0, 4, 3, 2));
    prog.push_back(rtype('h00, 7, 5, 3, 2));
    prog.push_back(rtype('h00, 6, 6, 1, 2));
    prog.push_back(rtype('h00, 4, 7, 3, 1));
    // write to x0, then read it back through an add
    prog.push_back(addi(0, 1, 5));
    prog.push_back(rtype('h00, 0, 8, 0, 2));
    prog.push_back(addi(9, 0, -1));
    prog.push_back(rtype('h20, 0, 10, 0, 9));
    prog.push_back(word_t'(OPC_TRAP));
    run_program(12, 1'b0);
    end_test();
  endtask

  task automatic test_load_store();
    begin_test("load and store");
    prog.push_back(addi(1, 0, 'h100));
    prog.push_back(lui(2, 20'hcafe0));
    prog.push_back(addi(2, 2, 'h123));
    prog.push_back(sw(2, 1, 8));
    prog.push_back(lw(3, 1, 8));
    prog.push_back(lw(5, 1, -4));
    prog.push_back(rtype('h00, 0, 6, 3, 5));
    prog.push_back(sw(6, 1, 12));
    prog.push_back(lw(7, 1, 12));
    prog.push_back(word_t'(OPC_TRAP));
    run_program(10, 1'b0);
    check_word("memory at 0x108", mem[66], 32'hcafe_0123);
    check_word("memory at 0x10c", mem[67], 32'hcafe_0123 + {24'hc0ffee, 8'd63});
    end_test();
  endtask

  task automatic test_branches();
    begin_test("branches");
    prog.push_back(addi(1, 0, 3));
    prog.push_back(addi(2, 0, 0));
    // three iterations of the loop body at 0x8
    prog.push_back(addi(2, 2, 1));
    prog.push_back(addi(1, 1, -1));
    prog.push_back(branch(1, 1, 0, -8));
    prog.push_back(branch(0, 2, 0, 8));
    prog.push_back(branch(0, 1, 0, 8));
    prog.push_back(addi(3, 0, 99));
    prog.push_back(branch(1, 2, 0, 8));
    prog.push_back(addi(3, 0, 77));
    prog.push_back(addi(4, 0, 5));
    prog.push_back(word_t'(OPC_TRAP));
    run_program(16, 1'b0);
    end_test();
  endtask

  task automatic test_trap_counters();
    begin_test("trap and counters");
    prog.push_back(addi(1, 0, 7));
    prog.push_back(addi(2, 1, -2));
    prog.push_back(word_t'(OPC_TRAP));
    prog.push_back(addi(3, 0, 1));
    run_program(3, 1'b0);
    end_test();
  endtask

  task automatic test_faults();
    begin_test("illegal opcode");
    prog.push_back(addi(1, 0, 1));
    prog.push_back(32'h0000_007f);
    prog.push_back(addi(2, 0, 2));
    run_program(1, 1'b1);
    end_test();
    begin_test("load error response");
    prog.push_back(addi(5, 0, 85));
    prog.push_back(addi(1, 0, 'h100));
    prog.push_back(lw(5, 1, 0));
    prog.push_back(word_t'(OPC_TRAP));
    load_err = 1'b1;
    run_program(2, 1'b1);
    load_err = 1'b0;
    check_word("x5 after faulted load", DUT.u_regfile.regs[5], 32'd85);
    end_test();
    begin_test("fetch error response");
    prog.push_back(addi(1, 0, 1));
    prog.push_back(addi(2, 0, 2));
    prog.push_back(addi(3, 0, 3));
    prog.push_back(word_t'(OPC_TRAP));
    fetch_err_addr = 32'h0000_0008;
    run_program(2, 1'b1);
    fetch_err_addr = 32'hffff_ffff;
    end_test();
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    reset        <= 1'b1;
    if_rw_ready  <= 1'b0;
    if_r_data    <= '0;
    if_rw_resp   <= RESP_OKAY;
    mem_rw_ready <= 1'b0;
    mem_r_data   <= '0;
    mem_rw_resp  <= RESP_OKAY;
    test_arithmetic();
    test_load_store();
    test_branches();
    test_trap_counters();
    test_faults();
    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* cpu.sv */
// core top level with fetch, data, commit and status ports
`timescale 1ns/1ps

module cpu
  import core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic       clock,
  input  logic       reset,
  output logic       if_rw_valid,
  input  logic       if_rw_ready,
  output word_t      if_rw_addr,
  input  word_t      if_r_data,
  input  logic [1:0] if_rw_resp,
  output logic       mem_rw_valid,
  input  logic       mem_rw_ready,
  output logic       mem_rw_req,
  output word_t      mem_rw_addr,
  output word_t      mem_w_data,
  input  word_t      mem_r_data,
  input  logic [1:0] mem_rw_resp,
  output logic       commit_valid,
  output word_t      commit_pc,
  output word_t      commit_inst,
  output logic       commit_wen,
  output reg_addr_t  commit_rd,
  output word_t      commit_data,
  output logic       halted,
  output logic       fault,
  output word_t      cycle_count,
  output word_t      instr_count
);

  word_t     inst;
  word_t     pc;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      reg_write_en;
  reg_addr_t reg_write_addr;
  word_t     reg_write_data;

  exec_result_if exec_bus ();

  regfile u_regfile (
    .clock      (clock),
    .reset      (reset),
    .read_addr1 (rs1_addr),
    .read_addr2 (rs2_addr),
    .read_data1 (rs1_data),
    .read_data2 (rs2_data),
    .write_en   (reg_write_en),
    .write_addr (reg_write_addr),
    .write_data (reg_write_data)
  );

  exec_unit u_exec_unit (
    .inst     (inst),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .result   (exec_bus.producer)
  );

  core_ctrl_fsm #(
    .RESET_PC (RESET_PC)
  ) u_ctrl (
    .clock          (clock),
    .reset          (reset),
    .exec           (exec_bus.consumer),
    .inst           (inst),
    .pc             (pc),
    .if_rw_valid    (if_rw_valid),
    .if_rw_ready    (if_rw_ready),
    .if_rw_addr     (if_rw_addr),
    .if_r_data      (if_r_data),
    .if_rw_resp     (if_rw_resp),
    .mem_rw_valid   (mem_rw_valid),
    .mem_rw_ready   (mem_rw_ready),
    .mem_rw_req     (mem_rw_req),
    .mem_rw_addr    (mem_rw_addr),
    .mem_w_data     (mem_w_data),
    .mem_r_data     (mem_r_data),
    .mem_rw_resp    (mem_rw_resp),
    .reg_write_en   (reg_write_en),
    .reg_write_addr (reg_write_addr),
    .reg_write_data (reg_write_data),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_inst    (commit_inst),
    .commit_wen     (commit_wen),
    .commit_rd      (commit_rd),
    .commit_data    (commit_data),
    .halted         (halted),
    .fault          (fault)
  );

  retire_counter u_counters (
    .clock       (clock),
    .reset       (reset),
    .retire      (commit_valid),
    .halted      (halted),
    .cycle_count (cycle_count),
    .instr_count (instr_count)
  );

endmodule

/* retire_counter.sv */
// cycle counter and retired instruction counter
`timescale 1ns/1ps

module retire_counter
  import core_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  retire,
  input  logic  halted,
  output word_t cycle_count,
  output word_t instr_count
);

  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= '0;
      instr_count <= '0;
    end else begin
      // frozen once the core stops
      if (!halted) begin
        cycle_count <= cycle_count + 1'b1;
      end
      if (retire) begin
        instr_count <= instr_count + 1'b1;
      end
    end
  end

endmodule

/* core_ctrl_fsm.sv */
// control FSM with PC, instruction and load registers, bus requests and commit
`timescale 1ns/1ps

module core_ctrl_fsm
  import core_pkg::*;
#(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic      clock,
  input  logic      reset,
  exec_result_if.consumer exec,
  output word_t     inst,
  output word_t     pc,
  output logic      if_rw_valid,
  input  logic      if_rw_ready,
  output word_t     if_rw_addr,
  input  word_t     if_r_data,
  input  logic [1:0] if_rw_resp,
  output logic      mem_rw_valid,
  input  logic      mem_rw_ready,
  output logic      mem_rw_req,
  output word_t     mem_rw_addr,
  output word_t     mem_w_data,
  input  word_t     mem_r_data,
  input  logic [1:0] mem_rw_resp,
  output logic      reg_write_en,
  output reg_addr_t reg_write_addr,
  output word_t     reg_write_data,
  output logic      commit_valid,
  output word_t     commit_pc,
  output word_t     commit_inst,
  output logic      commit_wen,
  output reg_addr_t commit_rd,
  output word_t     commit_data,
  output logic      halted,
  output logic      fault
);

  state_t state;
  word_t  load_data;
  logic   if_xfer;
  logic   mem_xfer;
  logic   is_trap;
  logic   retiring;

  assign if_rw_valid  = (state == S_FETCH);
  assign if_rw_addr   = pc;
  assign mem_rw_valid = (state == S_MEM);
  assign mem_rw_req   = exec.is_store;
  assign mem_rw_addr  = exec.mem_addr;
  assign mem_w_data   = exec.store_data;
  assign if_xfer      = if_rw_valid && if_rw_ready;
  assign mem_xfer     = mem_rw_valid && mem_rw_ready;
  assign is_trap      = (inst[6:0] == OPC_TRAP);
  assign halted       = (state == S_HALT);

  assign reg_write_en   = (state == S_WRITEBACK) && exec.reg_write && (exec.rd != '0);
  assign reg_write_addr = exec.rd;
  assign reg_write_data = exec.is_load ? load_data : exec.result;

  // writeback, or a trap leaving execute
  assign retiring = (state == S_WRITEBACK) || (state == S_EXECUTE && is_trap && !exec.illegal);

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= S_FETCH;
      pc           <= RESET_PC;
      fault        <= 1'b0;
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= retiring;
      case (state)
        S_FETCH: begin
          if (if_xfer) begin
            if (if_rw_resp != RESP_OKAY) begin
              state <= S_HALT;
              fault <= 1'b1;
            end else begin
              state <= S_EXECUTE;
            end
          end
        end
        S_EXECUTE: begin
          if (exec.illegal) begin
            state <= S_HALT;
            fault <= 1'b1;
          end else if (is_trap) begin
            state <= S_HALT;
          end else if (exec.is_load || exec.is_store) begin
            state <= S_MEM;
          end else begin
            state <= S_WRITEBACK;
          end
        end
        S_MEM: begin
          if (mem_xfer) begin
            if (mem_rw_resp != RESP_OKAY) begin
              state <= S_HALT;
              fault <= 1'b1;
            end else begin
              state <= S_WRITEBACK;
            end
          end
        end
        S_WRITEBACK: begin
          pc    <= exec.branch_taken ? exec.branch_target : pc + 32'd4;
          state <= S_FETCH;
        end
        default: ;
      endcase
    end
  end

  // instruction, load data and commit payload
  always_ff @(posedge clock) begin
    if (if_xfer && if_rw_resp == RESP_OKAY) inst <= if_r_data;
    if (mem_xfer && exec.is_load) load_data <= mem_r_data;
    if (retiring) begin
      commit_pc   <= pc;
      commit_inst <= inst;
      commit_wen  <= reg_write_en;
      commit_rd   <= exec.rd;
      commit_data <= reg_write_data;
    end
  end

  one_port_at_a_time: assert property (@(posedge clock) disable iff (reset)
    !(if_rw_valid && mem_rw_valid));

  fetch_req_held: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr));

  mem_req_held: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid && !mem_rw_ready |=>
      mem_rw_valid && $stable(mem_rw_addr) && $stable(mem_rw_req) && $stable(mem_w_data));

  no_commit_when_halted: assert property (@(posedge clock) disable iff (reset)
    state == S_HALT |=> !commit_valid);

endmodule

/* exec_unit.sv */
// instruction decode, ALU, address and branch target, illegal detection
`timescale 1ns/1ps

module exec_unit
  import core_pkg::*;
(
  input  word_t           inst,
  input  word_t           pc,
  input  word_t           rs1_data,
  input  word_t           rs2_data,
  output reg_addr_t       rs1_addr,
  output reg_addr_t       rs2_addr,
  exec_result_if.producer result
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  alu_op_t    alu_op;
  word_t      operand_b;
  word_t      alu_out;
  logic       is_branch;
  logic       operands_equal;

  assign opcode   = opcode_t'(inst[6:0]);
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  // immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    alu_op           = ALU_ADD;
    operand_b        = rs2_data;
    is_branch        = 1'b0;
    result.reg_write = 1'b0;
    result.is_load   = 1'b0;
    result.is_store  = 1'b0;
    result.illegal   = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_op           = ALU_PASS_B;
        operand_b        = imm_u;
        result.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        operand_b        = imm_i;
        result.reg_write = 1'b1;
        result.illegal   = (funct3 != F3_ADD_SUB);
      end
      OPC_OP: begin
        result.reg_write = 1'b1;
        if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) alu_op = ALU_SUB;
        else if (funct3 == F3_XOR) alu_op = ALU_XOR;
        else if (funct3 == F3_OR) alu_op = ALU_OR;
        else if (funct3 == F3_AND) alu_op = ALU_AND;
        // only ADD/SUB may carry a nonzero funct7
        result.illegal = (funct7 != F7_BASE) &&
                         !(funct3 == F3_ADD_SUB && funct7 == F7_SUB);
        if (funct3 != F3_ADD_SUB && funct3 != F3_XOR && funct3 != F3_OR &&
            funct3 != F3_AND) begin
          result.illegal = 1'b1;
        end
      end
      OPC_LOAD: begin
        result.reg_write = 1'b1;
        result.is_load   = 1'b1;
        result.illegal   = (funct3 != F3_WORD);
      end
      OPC_STORE: begin
        result.is_store = 1'b1;
        result.illegal  = (funct3 != F3_WORD);
      end
      OPC_BRANCH: begin
        is_branch      = 1'b1;
        result.illegal = (funct3 != F3_BEQ) && (funct3 != F3_BNE);
      end
      OPC_TRAP: ;
      default: result.illegal = 1'b1;
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_out = rs1_data + operand_b;
      ALU_SUB:    alu_out = rs1_data - operand_b;
      ALU_AND:    alu_out = rs1_data & operand_b;
      ALU_OR:     alu_out = rs1_data | operand_b;
      ALU_XOR:    alu_out = rs1_data ^ operand_b;
      ALU_PASS_B: alu_out = operand_b;
      default:    alu_out = '0;
    endcase
  end

  assign operands_equal = (rs1_data == rs2_data);

  assign result.rd            = inst[11:7];
  assign result.result        = alu_out;
  assign result.mem_addr      = rs1_data + (result.is_store ? imm_s : imm_i);
  assign result.store_data    = rs2_data;
  assign result.branch_target = pc + imm_b;
  // BNE inverts the equality test
  assign result.branch_taken  = is_branch &&
                                ((funct3 == F3_BNE) ? !operands_equal : operands_equal);

endmodule

/* regfile.sv */
// integer register file, 32 x 32 bits, two read ports and one write port
`timescale 1ns/1ps

module regfile
  import core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t read_addr1,
  input  reg_addr_t read_addr2,
  output word_t     read_data1,
  output word_t     read_data2,
  input  logic      write_en,
  input  reg_addr_t write_addr,
  input  word_t     write_data
);

  word_t regs [0:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  // x0 reads as zero
  assign read_data1 = (read_addr1 == '0) ? '0 : regs[read_addr1];
  assign read_data2 = (read_addr2 == '0) ? '0 : regs[read_addr2];

  // the control FSM never issues a write to x0
  x0_stays_zero: assert property (@(posedge clock) disable iff (reset) regs[0] == '0);

endmodule

/* exec_result_if.sv */
// decoded instruction and execute result, execute unit to control FSM
`timescale 1ns/1ps

interface exec_result_if
  import core_pkg::*;
();

  reg_addr_t rd;
  logic      reg_write;
  word_t     result;
  word_t     mem_addr;
  word_t     store_data;
  logic      is_load;
  logic      is_store;
  logic      branch_taken;
  word_t     branch_target;
  logic      illegal;

  modport producer (
    output rd, reg_write, result, mem_addr, store_data,
           is_load, is_store, branch_taken, branch_target, illegal
  );

  modport consumer (
    input rd, reg_write, result, mem_addr, store_data,
          is_load, is_store, branch_taken, branch_target, illegal
  );

endinterface

/* core_pkg.sv */
// shared word types, opcode, state and ALU enums, function and response codes
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'h37,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23,
    OPC_BRANCH = 7'h63,
    OPC_TRAP   = 7'h6b
  } opcode_t;

  typedef enum logic [2:0] {
    S_FETCH,
    S_EXECUTE,
    S_MEM,
    S_WRITEBACK,
    S_HALT
  } state_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_t;

  // funct3 / funct7 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [6:0] F7_BASE    = 7'h00;
  localparam logic [6:0] F7_SUB     = 7'h20;

  // bus response, anything else is an error
  localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage
